// ==== all.f ====
+incdir+testbench
logic/rvfi_pkg.sv
logic/lockstep_pkg.sv
logic/rvfi_record_fifo.sv
logic/rvfi_field_compare.sv
logic/rvfi_lockstep_ctrl.sv
logic/rvfi_lockstep_top.sv
testbench/tb_rvfi_lockstep.sv

// ==== logic/lockstep_pkg.sv ====
/*
  lockstep checker types: compared field positions, mismatch mask,
  per-pair result and controller states, plus FIFO and credit depths
*/

package lockstep_pkg;

  // number of compared fields, one mask bit each
  localparam int NUM_FIELDS = 17;

  // buffering on each side, the rm depth is also the sender's credit pool
  localparam int CORE_FIFO_DEPTH = 8;
  localparam int RM_FIFO_DEPTH   = 4;

  // bit position of each field in the mismatch mask
  typedef enum logic [$clog2(NUM_FIELDS)-1:0] {
    PC_RDATA, INSN, TRAP, HALT, DBG, DBG_MODE, NMIP, INTR, MODE,
    RD1_ADDR, RD1_WDATA, MEM_RMASK, MEM_WMASK, MEM_ADDR, MEM_WDATA,
    MEM_RDATA, PC_WDATA
  } check_field_e;

  typedef logic [NUM_FIELDS-1:0] mismatch_mask_t;

  // outcome of one compared pair
  typedef struct packed {
    mismatch_mask_t             mask;
    logic [rvfi_pkg::XLEN-1:0]  pc_rdata;
  } check_result_t;

  // only reset leaves the two error states
  typedef enum logic [1:0] {
    LS_RUN,
    LS_FAILED,
    LS_OVERFLOW
  } lockstep_state_e;

endpackage

// ==== logic/rvfi_field_compare.sv ====
/*
  field-by-field comparison of a core and reference-model record pair
  applies the register and memory masking rules, result is registered
*/

module rvfi_field_compare (
  input  logic                        rvfi_core,
  input  logic                        reset_i,
  input  logic                        pair_valid_i,
  input  rvfi_pkg::rvfi_retire_t      core_rec_i,
  input  rvfi_pkg::rvfi_retire_t      rm_rec_i,
  output logic                        result_valid_o,
  output lockstep_pkg::check_result_t result_o
);

  import lockstep_pkg::*;

  mismatch_mask_t mask_d;
  logic           rd_written;
  logic           core_reads;
  logic           core_writes;

  // register write data only matters for a real destination
  assign rd_written = (rm_rec_i.rd1_addr != '0);

  // memory qualifiers come from the core side
  assign core_reads  = (core_rec_i.mem_rmask != '0);
  assign core_writes = (core_rec_i.mem_wmask != '0);

  always_comb begin
    mask_d = '0;

    // always compared
    mask_d[PC_RDATA]  = (core_rec_i.pc_rdata != rm_rec_i.pc_rdata);
    mask_d[INSN]      = (core_rec_i.insn != rm_rec_i.insn);
    mask_d[TRAP]      = (core_rec_i.trap != rm_rec_i.trap);
    mask_d[HALT]      = (core_rec_i.halt != rm_rec_i.halt);
    mask_d[DBG]       = (core_rec_i.dbg != rm_rec_i.dbg);
    mask_d[DBG_MODE]  = (core_rec_i.dbg_mode != rm_rec_i.dbg_mode);
    mask_d[NMIP]      = (core_rec_i.nmip != rm_rec_i.nmip);
    mask_d[INTR]      = (core_rec_i.intr != rm_rec_i.intr);
    mask_d[MODE]      = (core_rec_i.mode != rm_rec_i.mode);
    mask_d[RD1_ADDR]  = (core_rec_i.rd1_addr != rm_rec_i.rd1_addr);
    mask_d[MEM_RMASK] = (core_rec_i.mem_rmask != rm_rec_i.mem_rmask);
    mask_d[MEM_WMASK] = (core_rec_i.mem_wmask != rm_rec_i.mem_wmask);
    mask_d[PC_WDATA]  = (core_rec_i.pc_wdata != rm_rec_i.pc_wdata);

    // qualified fields
    mask_d[RD1_WDATA] = rd_written &&
                        (core_rec_i.rd1_wdata != rm_rec_i.rd1_wdata);
    mask_d[MEM_ADDR]  = (core_reads || core_writes) &&
                        (core_rec_i.mem_addr != rm_rec_i.mem_addr);
    mask_d[MEM_WDATA] = core_writes &&
                        (core_rec_i.mem_wdata != rm_rec_i.mem_wdata);
    mask_d[MEM_RDATA] = core_reads &&
                        (core_rec_i.mem_rdata != rm_rec_i.mem_rdata);
  end

  always_ff @(posedge rvfi_core) begin
    if (reset_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= pair_valid_i;
    end
  end

  // result payload only loads with a pair
  always_ff @(posedge rvfi_core) begin
    if (pair_valid_i) begin
      result_o.mask     <= mask_d;
      result_o.pc_rdata <= core_rec_i.pc_rdata;
    end
  end

endmodule

// ==== logic/rvfi_lockstep_ctrl.sv ====
/*
  lockstep controller: pairing FSM, pop and credit return strobe,
  sticky failure with first failing result, overflow and retired counter
*/

module rvfi_lockstep_ctrl (
  input  logic                        rvfi_core,
  input  logic                        reset_i,
  input  logic                        core_empty_i,
  input  logic                        core_full_i,
  input  logic                        rm_empty_i,
  input  logic                        core_valid_i,
  output logic                        pop_o,
  input  logic                        cmp_valid_i,
  input  lockstep_pkg::check_result_t cmp_result_i,
  output logic                        credit_return_o,
  output logic                        result_valid_o,
  output lockstep_pkg::check_result_t result_o,
  output lockstep_pkg::check_result_t first_fail_o,
  output logic                        fail_o,
  output logic                        overflow_o,
  output logic [31:0]                 retired_count_o
);

  import lockstep_pkg::*;

  lockstep_state_e state_q;
  lockstep_state_e state_d;
  logic            pair_fail;
  logic            core_overflow;
  logic            running;

  assign running = (state_q == LS_RUN);

  // a failing result is visible here one cycle before state moves
  assign pair_fail = cmp_valid_i && (cmp_result_i.mask != '0);

  // core retirement has nowhere to go
  assign core_overflow = core_valid_i && core_full_i;

  // no new pair once an error is seen, so nothing more leaves the FIFOs
  assign pop_o = running && !core_empty_i && !rm_empty_i &&
                 !pair_fail && !core_overflow;

  // each popped reference record frees one slot for the sender
  assign credit_return_o = pop_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      LS_RUN: begin
        if (pair_fail) begin
          state_d = LS_FAILED;
        end else if (core_overflow) begin
          state_d = LS_OVERFLOW;
        end
      end
      LS_FAILED:   state_d = LS_FAILED;
      LS_OVERFLOW: state_d = LS_OVERFLOW;
      default:     state_d = LS_RUN;
    endcase
  end

  always_ff @(posedge rvfi_core) begin
    if (reset_i) begin
      state_q <= LS_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign fail_o     = (state_q == LS_FAILED);
  assign overflow_o = (state_q == LS_OVERFLOW);

  // result strobe and pair count
  always_ff @(posedge rvfi_core) begin
    if (reset_i) begin
      result_valid_o  <= 1'b0;
      retired_count_o <= '0;
    end else begin
      result_valid_o <= cmp_valid_i;
      if (cmp_valid_i) begin
        retired_count_o <= retired_count_o + 32'd1;
      end
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (cmp_valid_i) begin
      result_o <= cmp_result_i;
    end
  end

  // keep only the first failure
  always_ff @(posedge rvfi_core) begin
    if (reset_i) begin
      first_fail_o <= '0;
    end else if (running && pair_fail) begin
      first_fail_o <= cmp_result_i;
    end
  end

endmodule

// ==== logic/rvfi_lockstep_top.sv ====
/*
  RVFI lockstep checker top level
  core and reference-model FIFOs, controller and field comparator
*/

module rvfi_lockstep_top (
  input  logic                        rvfi_core,
  input  logic                        reset_i,
  // core retirement stream, no back-pressure
  input  logic                        core_valid_i,
  input  rvfi_pkg::rvfi_retire_t      core_rec_i,
  // reference-model stream under credit flow control
  input  logic                        rm_valid_i,
  input  rvfi_pkg::rvfi_retire_t      rm_rec_i,
  output logic                        credit_return_o,
  // check results and status
  output logic                        result_valid_o,
  output lockstep_pkg::check_result_t result_o,
  output lockstep_pkg::check_result_t first_fail_o,
  output logic                        fail_o,
  output logic                        overflow_o,
  output logic [31:0]                 retired_count_o
);

  import rvfi_pkg::*;
  import lockstep_pkg::*;

  rvfi_retire_t  core_head;
  rvfi_retire_t  rm_head;
  logic          core_empty;
  logic          core_full;
  logic          rm_empty;
  logic          pop;
  logic          cmp_valid;
  check_result_t cmp_result;

  rvfi_record_fifo #(
    .DEPTH (CORE_FIFO_DEPTH)
  ) u_core_fifo (
    .rvfi_core  (rvfi_core),
    .reset_i    (reset_i),
    .push_i     (core_valid_i),
    .push_rec_i (core_rec_i),
    .pop_i      (pop),
    .head_o     (core_head),
    .empty_o    (core_empty),
    .full_o     (core_full)
  );

  // credits keep this one from ever filling past its depth
  rvfi_record_fifo #(
    .DEPTH (RM_FIFO_DEPTH)
  ) u_rm_fifo (
    .rvfi_core  (rvfi_core),
    .reset_i    (reset_i),
    .push_i     (rm_valid_i),
    .push_rec_i (rm_rec_i),
    .pop_i      (pop),
    .head_o     (rm_head),
    .empty_o    (rm_empty),
    .full_o     ()
  );

  rvfi_lockstep_ctrl u_ctrl (
    .rvfi_core       (rvfi_core),
    .reset_i         (reset_i),
    .core_empty_i    (core_empty),
    .core_full_i     (core_full),
    .rm_empty_i      (rm_empty),
    .core_valid_i    (core_valid_i),
    .pop_o           (pop),
    .cmp_valid_i     (cmp_valid),
    .cmp_result_i    (cmp_result),
    .credit_return_o (credit_return_o),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o),
    .first_fail_o    (first_fail_o),
    .fail_o          (fail_o),
    .overflow_o      (overflow_o),
    .retired_count_o (retired_count_o)
  );

  rvfi_field_compare u_cmp (
    .rvfi_core      (rvfi_core),
    .reset_i        (reset_i),
    .pair_valid_i   (pop),
    .core_rec_i     (core_head),
    .rm_rec_i       (rm_head),
    .result_valid_o (cmp_valid),
    .result_o       (cmp_result)
  );

endmodule

// ==== logic/rvfi_pkg.sv ====
/*
  RVFI retirement record shared by the core and reference-model streams
  field widths and the packed record without its valid bit
*/

package rvfi_pkg;

  // data and address width
  localparam int XLEN = 32;

  // widths of the narrow status fields
  localparam int DBG_W      = 3;
  localparam int NMIP_W     = 2;
  localparam int INTR_W     = 11;
  localparam int MODE_W     = 2;
  localparam int REG_ADDR_W = 5;

  // one byte-enable bit per byte of a data word
  localparam int MEM_MASK_W = XLEN / 8;

  // one retired instruction
  typedef struct packed {
    logic [XLEN-1:0]       pc_rdata;
    logic [XLEN-1:0]       insn;
    logic [XLEN-1:0]       pc_wdata;
    logic                  trap;
    logic                  halt;
    logic                  dbg_mode;
    logic [DBG_W-1:0]      dbg;
    logic [NMIP_W-1:0]     nmip;
    // bit 0 flags a taken trap, cause sits above it
    logic [INTR_W-1:0]     intr;
    logic [MODE_W-1:0]     mode;
    // destination register write
    logic [REG_ADDR_W-1:0] rd1_addr;
    logic [XLEN-1:0]       rd1_wdata;
    // data memory access
    logic [XLEN-1:0]       mem_addr;
    logic [MEM_MASK_W-1:0] mem_rmask;
    logic [MEM_MASK_W-1:0] mem_wmask;
    logic [XLEN-1:0]       mem_wdata;
    logic [XLEN-1:0]       mem_rdata;
  } rvfi_retire_t;

endpackage

// ==== logic/rvfi_record_fifo.sv ====
/*
  circular FIFO of retirement records
  combinational head, full and empty flags, pushes into a full FIFO are dropped
*/

module rvfi_record_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                   rvfi_core,
  input  logic                   reset_i,
  input  logic                   push_i,
  input  rvfi_pkg::rvfi_retire_t push_rec_i,
  input  logic                   pop_i,
  output rvfi_pkg::rvfi_retire_t head_o,
  output logic                   empty_o,
  output logic                   full_o
);

  import rvfi_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  rvfi_retire_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign head_o = mem[rd_ptr_q];

  // storage has no reset, occupancy decides what is valid
  always_ff @(posedge rvfi_core) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_rec_i;
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count unchanged
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== run_verilator.sh ====
#!/bin/sh
# build and run the lockstep checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_rvfi_lockstep \
  -f all.f \
  --Mdir obj_dir

./obj_dir/Vtb_rvfi_lockstep > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// ==== testbench/tb_lockstep_ref.svh ====
/*
  testbench helpers: LCG, random record generator,
  reference mismatch mask and typed compare tasks
*/

`ifndef TB_LOCKSTEP_REF_SVH
`define TB_LOCKSTEP_REF_SVH

  logic [31:0] lcg_state = 32'd95;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // sequential pc, everything else random
  function automatic rvfi_retire_t random_record(input logic [XLEN-1:0] pc);
    rvfi_retire_t rec;
    logic [31:0]  bits;
    rec           = '0;
    rec.pc_rdata  = pc;
    rec.pc_wdata  = pc + 32'd4;
    rec.insn      = next_rand();
    bits          = next_rand();
    rec.trap      = bits[31];
    rec.halt      = bits[30];
    rec.dbg_mode  = bits[29];
    rec.dbg       = bits[28:26];
    rec.nmip      = bits[25:24];
    rec.intr      = bits[23:13];
    rec.mode      = bits[12:11];
    bits          = next_rand();
    rec.rd1_addr  = bits[31:27];
    rec.mem_rmask = bits[26:23];
    rec.mem_wmask = bits[22:19];
    rec.rd1_wdata = next_rand();
    rec.mem_addr  = next_rand();
    rec.mem_wdata = next_rand();
    rec.mem_rdata = next_rand();
    return rec;
  endfunction

  // expected mismatch mask of one core and reference pair
  function automatic mismatch_mask_t expected_mask(input rvfi_retire_t c,
                                                   input rvfi_retire_t r);
    mismatch_mask_t m;
    logic           mem_used;
    m           = '0;
    mem_used    = (c.mem_rmask != 4'h0) || (c.mem_wmask != 4'h0);
    m[PC_RDATA] = (c.pc_rdata != r.pc_rdata);
    m[INSN]     = (c.insn != r.insn);
    m[TRAP]     = (c.trap != r.trap);
    m[HALT]     = (c.halt != r.halt);
    m[DBG]      = (c.dbg != r.dbg);
    m[DBG_MODE] = (c.dbg_mode != r.dbg_mode);
    m[NMIP]     = (c.nmip != r.nmip);
    m[INTR]     = (c.intr != r.intr);
    m[MODE]     = (c.mode != r.mode);
    m[RD1_ADDR] = (c.rd1_addr != r.rd1_addr);
    m[MEM_RMASK] = (c.mem_rmask != r.mem_rmask);
    m[MEM_WMASK] = (c.mem_wmask != r.mem_wmask);
    m[PC_WDATA]  = (c.pc_wdata != r.pc_wdata);
    // x0 writes carry no data
    if (r.rd1_addr != 5'd0) begin
      m[RD1_WDATA] = (c.rd1_wdata != r.rd1_wdata);
    end
    if (mem_used) begin
      m[MEM_ADDR] = (c.mem_addr != r.mem_addr);
    end
    if (c.mem_wmask != 4'h0) begin
      m[MEM_WDATA] = (c.mem_wdata != r.mem_wdata);
    end
    if (c.mem_rmask != 4'h0) begin
      m[MEM_RDATA] = (c.mem_rdata != r.mem_rdata);
    end
    return m;
  endfunction

  task automatic check_result(input string name, input check_result_t got,
                              input check_result_t want);
    if (got !== want) begin
      $display("mismatch %s got mask %h pc %h expected mask %h pc %h",
               name, got.mask, got.pc_rdata, want.mask, want.pc_rdata);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("mismatch %s got %h expected %h", name, got, want);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("mismatch %s got %h expected %h", name, got, want);
      stop_with_failure();
    end
  endtask

`endif

// ==== testbench/tb_rvfi_lockstep.sv ====
/*
  testbench for the RVFI lockstep checker
  clock and reset, credit-respecting stream sender,
  result comparison and the test sequence
*/

module tb_rvfi_lockstep;

  import rvfi_pkg::*;
  import lockstep_pkg::*;

  localparam int MATCH_PAIRS   = 40;
  localparam int MASK_PAIRS    = 16;
  localparam int INJECT_PAIRS  = 16;
  localparam int INJECT_INDEX  = 10;
  localparam int QUIET_CYCLES  = 20;
  localparam int TOTAL_RECORDS = 2 * (MATCH_PAIRS + MASK_PAIRS + INJECT_PAIRS) +
                                 CORE_FIFO_DEPTH + 1;
  localparam int CYCLE_LIMIT   = 20 * TOTAL_RECORDS;

  // kinds of generated pairs
  localparam int KIND_MATCH  = 0;
  localparam int KIND_MASKED = 1;
  localparam int KIND_INJECT = 2;

  logic          rvfi_core    = 1'b0;
  logic          reset_i      = 1'b1;
  logic          core_valid_i = 1'b0;
  rvfi_retire_t  core_rec_i   = '0;
  logic          rm_valid_i   = 1'b0;
  rvfi_retire_t  rm_rec_i     = '0;
  logic          credit_return_o;
  logic          result_valid_o;
  check_result_t result_o;
  check_result_t first_fail_o;
  logic          fail_o;
  logic          overflow_o;
  logic [31:0]   retired_count_o;

  int cycle_count   = 0;
  int results_seen  = 0;
  int credit_pulses = 0;
  int rm_sent       = 0;

  // records waiting to be sent, and records sent but not yet checked
  rvfi_retire_t pend_core[$];
  rvfi_retire_t pend_rm[$];
  rvfi_retire_t exp_core_q[$];
  rvfi_retire_t exp_rm_q[$];

  task automatic stop_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "lockstep testbench stopped at first error");
  endtask

  `include "tb_lockstep_ref.svh"

  rvfi_lockstep_top u_dut (
    .rvfi_core       (rvfi_core),
    .reset_i         (reset_i),
    .core_valid_i    (core_valid_i),
    .core_rec_i      (core_rec_i),
    .rm_valid_i      (rm_valid_i),
    .rm_rec_i        (rm_rec_i),
    .credit_return_o (credit_return_o),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o),
    .first_fail_o    (first_fail_o),
    .fail_o          (fail_o),
    .overflow_o      (overflow_o),
    .retired_count_o (retired_count_o)
  );

  always begin
    #10 rvfi_core = ~rvfi_core;
  end

  always @(posedge rvfi_core) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_with_failure();
    end
  end

  // credits handed back to the sender
  always @(posedge rvfi_core) begin
    if (reset_i) begin
      credit_pulses <= 0;
    end else if (credit_return_o) begin
      credit_pulses <= credit_pulses + 1;
    end
  end

  task automatic check_next_result();
    rvfi_retire_t  c;
    rvfi_retire_t  r;
    check_result_t want;
    if (exp_core_q.size() == 0 || exp_rm_q.size() == 0) begin
      $display("result_valid_o rose with no record pair outstanding");
      stop_with_failure();
    end else begin
      c             = exp_core_q.pop_front();
      r             = exp_rm_q.pop_front();
      want.mask     = expected_mask(c, r);
      want.pc_rdata = c.pc_rdata;
      check_result("result_o", result_o, want);
      check_bit("fail_o", fail_o, want.mask != '0);
      if (want.mask != '0) begin
        check_result("first_fail_o", first_fail_o, want);
      end
    end
  endtask

  always @(posedge rvfi_core) begin
    if (reset_i) begin
      results_seen <= 0;
    end else if (result_valid_o) begin
      check_next_result();
      results_seen <= results_seen + 1;
    end
  end

  task automatic apply_reset();
    @(posedge rvfi_core);
    reset_i      <= 1'b1;
    core_valid_i <= 1'b0;
    rm_valid_i   <= 1'b0;
    repeat (16) @(posedge rvfi_core);
    exp_core_q.delete();
    exp_rm_q.delete();
    rm_sent = 0;
    reset_i <= 1'b0;
  endtask

  task automatic build_pairs(input int n, input int kind);
    rvfi_retire_t c;
    rvfi_retire_t r;
    pend_core.delete();
    pend_rm.delete();
    for (int i = 0; i < n; i++) begin
      c = random_record(32'h8000_0000 + 32'(4 * i));
      if (kind == KIND_MASKED && (i % 2) == 0) begin
        c.rd1_addr = '0;
      end else if (kind == KIND_MASKED) begin
        c.mem_rmask = '0;
        c.mem_wmask = '0;
      end
      r = c;
      if (kind == KIND_MASKED && (i % 2) == 0) begin
        r.rd1_wdata = ~c.rd1_wdata;
      end else if (kind == KIND_MASKED) begin
        r.mem_addr  = ~c.mem_addr;
        r.mem_wdata = ~c.mem_wdata;
        r.mem_rdata = ~c.mem_rdata;
      end else if (kind == KIND_INJECT && i == INJECT_INDEX) begin
        r.insn = ~c.insn;
      end
      pend_core.push_back(c);
      pend_rm.push_back(r);
    end
  endtask

  // both streams, rm side spends credits and takes random gaps
  task automatic run_streams(input int n, input bit stop_on_fail);
    int          ci;
    int          ri;
    int          credits;
    logic [31:0] draw;
    ci = 0;
    ri = 0;
    while ((ci < n || ri < n) && !(stop_on_fail && fail_o)) begin
      @(posedge rvfi_core);
      credits = RM_FIFO_DEPTH + credit_pulses - rm_sent;
      // more credits than the depth means a return without a popped record
      if (credits < 0 || credits > RM_FIFO_DEPTH) begin
        $display("sender credit count left the range from zero to the FIFO depth");
        stop_with_failure();
      end else begin
        core_valid_i <= 1'b0;
        rm_valid_i   <= 1'b0;
        draw = next_rand();
        // core stays at most two records ahead so its FIFO never fills
        if (ci < n && ci - ri < 2 && draw[31]) begin
          core_valid_i <= 1'b1;
          core_rec_i   <= pend_core[ci];
          exp_core_q.push_back(pend_core[ci]);
          ci++;
        end
        if (ri < n && credits > 0 && draw[30:29] != 2'b00) begin
          rm_valid_i <= 1'b1;
          rm_rec_i   <= pend_rm[ri];
          exp_rm_q.push_back(pend_rm[ri]);
          ri++;
          rm_sent++;
        end
      end
    end
    @(posedge rvfi_core);
    core_valid_i <= 1'b0;
    rm_valid_i   <= 1'b0;
  endtask

  // back-to-back core retirements with the reference side idle
  task automatic retire_core_only(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge rvfi_core);
      core_valid_i <= 1'b1;
      core_rec_i   <= random_record(32'h9000_0000 + 32'(4 * i));
    end
    @(posedge rvfi_core);
    core_valid_i <= 1'b0;
  endtask

  task automatic wait_results(input int n);
    while (results_seen < n) begin
      @(posedge rvfi_core);
    end
  endtask

  initial begin
    check_result_t want;
    int            pulses_at_fail;

    apply_reset();

    // matching streams, credit accounting checked on the same run
    build_pairs(MATCH_PAIRS, KIND_MATCH);
    run_streams(MATCH_PAIRS, 1'b0);
    wait_results(MATCH_PAIRS);
    check_count("retired_count_o", retired_count_o, 32'(MATCH_PAIRS));
    check_count("credit_return_o pulses", 32'(credit_pulses), 32'(rm_sent));
    check_bit("fail_o", fail_o, 1'b0);

    // differences hidden by the masking rules
    apply_reset();
    build_pairs(MASK_PAIRS, KIND_MASKED);
    run_streams(MASK_PAIRS, 1'b0);
    wait_results(MASK_PAIRS);
    check_count("retired_count_o", retired_count_o, 32'(MASK_PAIRS));
    check_bit("fail_o", fail_o, 1'b0);

    // insn corrupted on one pair
    apply_reset();
    build_pairs(INJECT_PAIRS, KIND_INJECT);
    run_streams(INJECT_PAIRS, 1'b1);
    wait_results(INJECT_INDEX + 1);
    check_bit("fail_o", fail_o, 1'b1);
    want.mask       = '0;
    want.mask[INSN] = 1'b1;
    want.pc_rdata   = pend_core[INJECT_INDEX].pc_rdata;
    check_result("first_fail_o", first_fail_o, want);
    check_result("result_o", result_o, want);
    pulses_at_fail = credit_pulses;
    repeat (QUIET_CYCLES) @(posedge rvfi_core);
    check_count("results after failure", 32'(results_seen), 32'(INJECT_INDEX + 1));
    check_count("credit_return_o pulses after failure", 32'(credit_pulses),
                32'(pulses_at_fail));
    check_count("retired_count_o", retired_count_o, 32'(INJECT_INDEX + 1));
    check_bit("fail_o", fail_o, 1'b1);

    // core FIFO overflow
    apply_reset();
    retire_core_only(CORE_FIFO_DEPTH + 1);
    for (int i = 0; i < QUIET_CYCLES && !overflow_o; i++) begin
      @(posedge rvfi_core);
    end
    check_bit("overflow_o", overflow_o, 1'b1);
    check_bit("fail_o", fail_o, 1'b0);
    check_count("retired_count_o", retired_count_o, 32'd0);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
